//--- include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and memory widths
`define CPU_DATA_W 16     // data word
`define CPU_ADDR_W 10     // physical RAM address
`define CPU_REGION_W 8    // logical address inside one slot region

// process slots
`define CPU_NUM_TASKS 3   // up to 4 fit in the upper address bits
`define CPU_NUM_REGS 8    // registers per slot

// scheduling
`define CPU_SLICE_LEN 3   // retired instructions per slice
`define CPU_PROG_START 16 // logical start address of every program

`endif

//--- logic/cpu_isa_pkg.sv
`default_nettype none
`include "cpu_defines.svh"

package cpu_isa_pkg;

  typedef logic [`CPU_DATA_W-1:0]   word_t;        // data and operand word
  typedef logic [`CPU_REGION_W-1:0] logic_addr_t;  // address seen by a process
  typedef logic [`CPU_ADDR_W-1:0]   phys_addr_t;   // RAM address
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;  // low bits of the register byte

  // high byte of the first instruction word
  typedef enum logic [7:0] {
    JMP       = 8'd1,  // pc = operand
    RAM2REG   = 8'd2,  // reg = ram[operand]
    REG2RAM   = 8'd3,  // ram[operand] = reg
    NUM2REG   = 8'd4,  // reg = operand
    REG_PLUS  = 8'd5,  // reg += operand
    REG_MINUS = 8'd6   // reg -= operand
  } opcode_e;

endpackage

`default_nettype wire

//--- logic/cpu_ctrl_pkg.sv
`default_nettype none
`include "cpu_defines.svh"

package cpu_ctrl_pkg;

  // slot index fills the address bits above the logical region
  typedef logic [`CPU_ADDR_W-`CPU_REGION_W-1:0] task_idx_t;

  typedef enum logic [2:0] {
    FETCH_OP,   // opcode word address on the RAM
    LATCH_OP,   // capture opcode and register byte
    FETCH_ARG,  // operand word address on the RAM
    LATCH_ARG,  // capture operand, step pc
    EXEC,       // execute or start the data read
    LOAD_WAIT,  // data read in flight
    LOAD_DONE   // write loaded word to the register
  } seq_state_e;

endpackage

`default_nettype wire

//--- logic/ctx_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// broadcast from the sequencer to every slot, only the active slot takes it
interface ctx_wr_if;
  import cpu_isa_pkg::*;

  logic        reg_we;   // one-cycle strobe
  reg_idx_t    wr_reg;
  word_t       wr_data;
  logic        pc_we;    // one-cycle strobe
  logic_addr_t pc_data;
  reg_idx_t    rd_reg;   // level, selects the read-back register

  modport seq (output reg_we, wr_reg, wr_data, pc_we, pc_data, rd_reg);
  modport ctx (input reg_we, wr_reg, wr_data, pc_we, pc_data, rd_reg);

endinterface

`default_nettype wire

//--- logic/program_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module program_ram (
  input  logic                    clka,
  input  logic                    load_we,
  input  cpu_isa_pkg::phys_addr_t load_addr,
  input  cpu_isa_pkg::word_t      load_data,
  input  logic                    core_we,
  input  cpu_isa_pkg::phys_addr_t core_addr,
  input  cpu_isa_pkg::word_t      core_wdata,
  input  cpu_isa_pkg::phys_addr_t rd_addr,
  output cpu_isa_pkg::word_t      rd_data
);
  import cpu_isa_pkg::*;

  word_t mem [1 << `CPU_ADDR_W];

  always_ff @(posedge clka) begin
    if (load_we) begin
      mem[load_addr] <= load_data;  // loader wins over the core
    end else if (core_we) begin
      mem[core_addr] <= core_wdata;
    end
    rd_data <= mem[rd_addr];  // one cycle read latency
  end

endmodule

`default_nettype wire

//--- logic/inst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module inst_sequencer (
  input  logic                     clka,
  input  logic                     rst,
  input  logic                     run,
  input  cpu_ctrl_pkg::task_idx_t  cur_task,
  input  cpu_isa_pkg::logic_addr_t cur_pc,
  input  cpu_isa_pkg::word_t       cur_rd_data,
  output cpu_isa_pkg::phys_addr_t  rd_addr,
  input  cpu_isa_pkg::word_t       rd_data,
  output logic                     mem_we,
  output cpu_isa_pkg::phys_addr_t  mem_addr,
  output cpu_isa_pkg::word_t       mem_wdata,
  output logic                     inst_done,
  ctx_wr_if.seq                    wr
);
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  seq_state_e  state;
  opcode_e     op_q;       // may hold an unlisted value, retired as no-op
  reg_idx_t    reg_q;
  word_t       arg_q;
  logic_addr_t arg_pc;
  phys_addr_t  data_addr;

  assign arg_pc    = cur_pc + logic_addr_t'(1);
  assign data_addr = {cur_task, logic_addr_t'(arg_q)};  // slot region + logical address

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= FETCH_OP;
    end else begin
      case (state)
        FETCH_OP:  if (run) state <= LATCH_OP;
        LATCH_OP:  state <= FETCH_ARG;
        FETCH_ARG: state <= LATCH_ARG;
        LATCH_ARG: state <= EXEC;
        EXEC:      state <= (op_q == RAM2REG) ? LOAD_WAIT : FETCH_OP;
        LOAD_WAIT: state <= LOAD_DONE;
        default:   state <= FETCH_OP;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == LATCH_OP) begin
      op_q  <= opcode_e'(rd_data[15:8]);
      reg_q <= reg_idx_t'(rd_data[7:0]);  // register byte truncated
    end
    if (state == LATCH_ARG) begin
      arg_q <= rd_data;
    end
  end

  // read address, held through LOAD_WAIT so the word is still there in LOAD_DONE
  always_comb begin
    case (state)
      FETCH_ARG:       rd_addr = {cur_task, arg_pc};
      EXEC, LOAD_WAIT: rd_addr = data_addr;
      default:         rd_addr = {cur_task, cur_pc};
    endcase
  end

  always_comb begin
    wr.reg_we  = 1'b0;
    wr.wr_reg  = reg_q;
    wr.wr_data = arg_q;
    wr.pc_we   = 1'b0;
    wr.pc_data = cur_pc + logic_addr_t'(2);  // next instruction
    wr.rd_reg  = reg_q;
    mem_we     = 1'b0;
    inst_done  = 1'b0;
    case (state)
      LATCH_ARG: wr.pc_we = 1'b1;
      EXEC: begin
        inst_done = (op_q != RAM2REG);
        case (op_q)
          JMP: begin
            wr.pc_we   = 1'b1;
            wr.pc_data = logic_addr_t'(arg_q);  // overrides the step from LATCH_ARG
          end
          NUM2REG:  wr.reg_we = 1'b1;
          REG_PLUS: begin
            wr.reg_we  = 1'b1;
            wr.wr_data = cur_rd_data + arg_q;
          end
          REG_MINUS: begin
            wr.reg_we  = 1'b1;
            wr.wr_data = cur_rd_data - arg_q;  // wraps below 0
          end
          REG2RAM:  mem_we = 1'b1;
          default:  ;
        endcase
      end
      LOAD_DONE: begin
        wr.reg_we  = 1'b1;
        wr.wr_data = rd_data;
        inst_done  = 1'b1;
      end
      default: ;
    endcase
  end

  assign mem_addr  = data_addr;
  assign mem_wdata = cur_rd_data;  // rd_reg selects the source register

endmodule

`default_nettype wire

//--- logic/task_context.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module task_context #(
  parameter int unsigned slot_id = 0
) (
  input  logic                     clka,
  input  logic                     rst,
  ctx_wr_if.ctx                    wr,
  input  cpu_ctrl_pkg::task_idx_t  cur_task,
  output cpu_isa_pkg::logic_addr_t pc,
  output cpu_isa_pkg::word_t       rd_data
);
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  word_t regs [`CPU_NUM_REGS];
  logic  active;

  assign active = (cur_task == task_idx_t'(slot_id));

  always_ff @(posedge clka) begin
    if (!rst) begin
      pc <= logic_addr_t'(`CPU_PROG_START);
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (active) begin  // idle slots keep their state
      if (wr.pc_we) begin
        pc <= wr.pc_data;
      end
      if (wr.reg_we) begin
        regs[wr.wr_reg] <= wr.wr_data;
      end
    end
  end

  assign rd_data = regs[wr.rd_reg];

endmodule

`default_nettype wire

//--- logic/slice_scheduler.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module slice_scheduler (
  input  logic                     clka,
  input  logic                     rst,
  input  logic                     inst_done,
  input  cpu_isa_pkg::logic_addr_t slot_pc      [`CPU_NUM_TASKS],
  input  cpu_isa_pkg::word_t       slot_rd_data [`CPU_NUM_TASKS],
  output cpu_ctrl_pkg::task_idx_t  cur_task,
  output cpu_isa_pkg::logic_addr_t cur_pc,
  output cpu_isa_pkg::word_t       cur_rd_data
);
  import cpu_ctrl_pkg::*;

  localparam int unsigned CNT_W = $clog2(`CPU_SLICE_LEN + 1);

  logic [CNT_W-1:0] slice_cnt;  // instructions retired in this slice
  logic             slice_end;

  assign slice_end = inst_done && (slice_cnt == CNT_W'(`CPU_SLICE_LEN - 1));

  always_ff @(posedge clka) begin
    if (!rst) begin
      slice_cnt <= '0;
      cur_task  <= '0;
    end else if (slice_end) begin
      slice_cnt <= '0;
      if (cur_task == task_idx_t'(`CPU_NUM_TASKS - 1)) begin
        cur_task <= '0;  // back to the first slot
      end else begin
        cur_task <= cur_task + task_idx_t'(1);
      end
    end else if (inst_done) begin
      slice_cnt <= slice_cnt + CNT_W'(1);
    end
  end

  // read-back of the active slot
  assign cur_pc      = slot_pc[cur_task];
  assign cur_rd_data = slot_rd_data[cur_task];

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_top (
  input  logic                    clka,
  input  logic                    rst,
  input  logic                    run,
  input  logic                    load_we,
  input  cpu_isa_pkg::phys_addr_t load_addr,
  input  cpu_isa_pkg::word_t      load_data,
  output logic                    mem_we,
  output cpu_isa_pkg::phys_addr_t mem_addr,
  output cpu_isa_pkg::word_t      mem_wdata,
  output cpu_ctrl_pkg::task_idx_t cur_task
);
  import cpu_isa_pkg::*;

  logic_addr_t slot_pc      [`CPU_NUM_TASKS];
  word_t       slot_rd_data [`CPU_NUM_TASKS];
  logic_addr_t cur_pc;
  word_t       cur_rd_data;
  phys_addr_t  rd_addr;
  word_t       rd_data;
  logic        inst_done;

  ctx_wr_if u_ctx_wr ();

  program_ram u_program_ram (
    .clka       (clka),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .core_we    (mem_we),  // stores go to RAM and out of the top
    .core_addr  (mem_addr),
    .core_wdata (mem_wdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  inst_sequencer u_inst_sequencer (
    .clka        (clka),
    .rst         (rst),
    .run         (run),
    .cur_task    (cur_task),
    .cur_pc      (cur_pc),
    .cur_rd_data (cur_rd_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .inst_done   (inst_done),
    .wr          (u_ctx_wr.seq)
  );

  slice_scheduler u_slice_scheduler (
    .clka         (clka),
    .rst          (rst),
    .inst_done    (inst_done),
    .slot_pc      (slot_pc),
    .slot_rd_data (slot_rd_data),
    .cur_task     (cur_task),
    .cur_pc       (cur_pc),
    .cur_rd_data  (cur_rd_data)
  );

  for (genvar g = 0; g < `CPU_NUM_TASKS; g++) begin : g_slot
    task_context #(
      .slot_id (g)
    ) u_task_context (
      .clka     (clka),
      .rst      (rst),
      .wr       (u_ctx_wr.ctx),
      .cur_task (cur_task),
      .pc       (slot_pc[g]),
      .rd_data  (slot_rd_data[g])
    );
  end

endmodule

`default_nettype wire

//--- test/cpu_top_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_top_checker (
  input logic                    clka,
  input logic                    rst,
  input logic                    run,
  input logic                    mem_we,
  input cpu_isa_pkg::phys_addr_t mem_addr,
  input cpu_ctrl_pkg::task_idx_t cur_task
);

  int unsigned assert_fails = 0;  // read by the testbench summary

  idle_no_store: assert property (@(posedge clka) disable iff (!rst) !run |-> !mem_we)
    else begin
      assert_fails = assert_fails + 1;
      $error("store issued while run is low");
    end

  single_store: assert property (@(posedge clka) disable iff (!rst) mem_we |=> !mem_we)
    else begin
      assert_fails = assert_fails + 1;
      $error("store strobe high for two cycles in a row");
    end

  // a store lands in the region of the active slot
  store_region: assert property (@(posedge clka) disable iff (!rst)
    mem_we |-> (mem_addr[`CPU_ADDR_W-1:`CPU_REGION_W] == cur_task))
    else begin
      assert_fails = assert_fails + 1;
      $error("store address outside the active slot region");
    end

  task_range: assert property (@(posedge clka) disable iff (!rst)
    int'(cur_task) < `CPU_NUM_TASKS)
    else begin
      assert_fails = assert_fails + 1;
      $error("active slot index out of range");
    end

endmodule

bind cpu_top cpu_top_checker u_cpu_top_checker (
  .clka     (clka),
  .rst      (rst),
  .run      (run),
  .mem_we   (mem_we),
  .mem_addr (mem_addr),
  .cur_task (cur_task)
);

`default_nettype wire

//--- test/cpu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_top_tb;
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;

  localparam int STIM_DEPTH   = 64;
  localparam int DRAIN_CYCLES = 2 * `CPU_NUM_TASKS * `CPU_SLICE_LEN * 7;  // two full rounds

  logic       clka;
  logic       rst;
  logic       run;
  logic       load_we;
  phys_addr_t load_addr;
  word_t      load_data;
  logic       mem_we;
  phys_addr_t mem_addr;
  word_t      mem_wdata;
  task_idx_t  cur_task;

  logic [31:0] stim [STIM_DEPTH];  // {kind, address, data}
  phys_addr_t  load_addr_q [$];
  word_t       load_data_q [$];
  phys_addr_t  exp_addr_q [$];
  word_t       exp_data_q [$];

  int n_exp       = 0;
  int seen        = 0;  // stores observed so far
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int addr_err    = 0;
  int data_err    = 0;
  int task_err    = 0;
  int extra_err   = 0;

  cpu_top u_cpu_top (
    .clka      (clka),
    .rst       (rst),
    .run       (run),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .cur_task  (cur_task)
  );

  initial begin
    clka = 1'b0;
    forever #4 clka = ~clka;
  end

  always @(posedge clka) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_addr(input string name, input phys_addr_t exp_val,
                            input phys_addr_t act_val);
    if (act_val !== exp_val) begin
      $display("error %s: address expected %h actual %h", name, exp_val, act_val);
      addr_err++;
    end
  endtask

  task automatic check_data(input string name, input word_t exp_val, input word_t act_val);
    if (act_val !== exp_val) begin
      $display("error %s: data expected %h actual %h", name, exp_val, act_val);
      data_err++;
    end
  endtask

  task automatic check_task(input string name, input task_idx_t exp_val,
                            input task_idx_t act_val);
    if (act_val !== exp_val) begin
      $display("error %s: slot expected %0d actual %0d", name, exp_val, act_val);
      task_err++;
    end
  endtask

  task automatic print_counts(input int missing);
    $display("errors: address %0d, data %0d, slot %0d, missing %0d, extra %0d, assertion %0d",
             addr_err, data_err, task_err, missing, extra_err,
             u_cpu_top.u_cpu_top_checker.assert_fails);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clka) begin
    if (mem_we === 1'b1) begin
      if (seen < n_exp) begin
        check_addr($sformatf("store %0d", seen), exp_addr_q[seen], mem_addr);
        check_data($sformatf("store %0d", seen), exp_data_q[seen], mem_wdata);
        check_task($sformatf("store %0d", seen),
                   task_idx_t'(exp_addr_q[seen] >> `CPU_REGION_W), cur_task);  // region owner
        seen = seen + 1;
      end else begin
        $display("extra store to address %h with data %h after the last expected store",
                 mem_addr, mem_wdata);
        extra_err++;
      end
    end
  end

  initial begin
    int i;
    rst       = 1'b0;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    $readmemh("test/cpu_stim.mem", stim);
    i = 0;
    while (i < STIM_DEPTH && (stim[i][31:28] === 4'h0 || stim[i][31:28] === 4'h1)) begin
      if (stim[i][31:28] === 4'h0) begin
        load_addr_q.push_back(phys_addr_t'(stim[i][27:16]));
        load_data_q.push_back(stim[i][15:0]);
      end else begin
        exp_addr_q.push_back(phys_addr_t'(stim[i][27:16]));
        exp_data_q.push_back(stim[i][15:0]);
      end
      i++;
    end
    n_exp       = exp_addr_q.size();
    cycle_limit = load_addr_q.size() + 7 * load_addr_q.size() * `CPU_NUM_TASKS + 200;

    repeat (16) @(negedge clka);
    rst = 1'b1;
    foreach (load_addr_q[k]) begin
      @(negedge clka);
      load_we   = 1'b1;
      load_addr = load_addr_q[k];
      load_data = load_data_q[k];
    end
    @(negedge clka);
    load_we = 1'b0;
    run     = 1'b1;

    wait (seen >= n_exp);
    repeat (DRAIN_CYCLES) @(negedge clka);  // programs park in a jump loop
    print_counts(0);
    if (addr_err + data_err + task_err + extra_err +
        u_cpu_top.u_cpu_top_checker.assert_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    wait (cycle_limit > 0);
    wait (cycle_cnt >= cycle_limit);
    $display("timeout after %0d cycles with only %0d of %0d expected stores seen",
             cycle_cnt, seen, n_exp);
    print_counts(n_exp - seen);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/ctx_wr_if.sv
logic/program_ram.sv
logic/inst_sequencer.sv
logic/task_context.sv
logic/slice_scheduler.sv
logic/cpu_top.sv
test/cpu_top_checker.sv
test/cpu_top_tb.sv

//--- Bender.yml
package:
  name: cpu_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_isa_pkg.sv
      - logic/cpu_ctrl_pkg.sv
      - logic/ctx_wr_if.sv
      - logic/program_ram.sv
      - logic/inst_sequencer.sv
      - logic/task_context.sv
      - logic/slice_scheduler.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/cpu_top_checker.sv
      - test/cpu_top_tb.sv

//--- test/cpu_stim.mem
// kind_address_data per line, kind 0 loads a word, kind 1 is the next expected store
// kind f ends the records, address holds 12 bits of which the low 10 are used
// slot 0 program
0_010_0401  // num2reg r1
0_011_1234
0_012_0301  // reg2ram r1 to 0x40
0_013_0040
0_014_0501  // reg_plus r1
0_015_0011
0_016_0602  // reg_minus r2 wraps below 0
0_017_0003
0_018_0301  // reg2ram r1 to 0x41
0_019_0041
0_01a_0302  // reg2ram r2 to 0x42
0_01b_0042
0_01c_0203  // ram2reg r3 from 0x70
0_01d_0070
0_01e_0303  // reg2ram r3 to 0x43
0_01f_0043
0_020_0100  // jmp 0x24
0_021_0024
0_022_0303  // skipped store
0_023_004f
0_024_7f03  // unknown opcode
0_025_9999
0_026_0303  // reg2ram r3 to 0x44
0_027_0044
0_028_0100  // park
0_029_0028
0_070_beef  // word for ram2reg
// slot 1 program
0_110_0400
0_111_0111
0_112_0300
0_113_0040
0_114_0100
0_115_0014
// slot 2 program
0_210_0400
0_211_0222
0_212_0300
0_213_0040
0_214_0100
0_215_0014
// expected stores in order
1_040_1234
1_140_0111
1_240_0222
1_041_1245
1_042_fffd
1_043_beef
1_044_beef
f_000_0000
